// File: source/csr_pkg.sv
package csr_pkg;

    localparam int xlen = 64;

    // machine-mode CSR addresses
    localparam logic [11:0] csr_addr_mscratch  = 12'h340;
    localparam logic [11:0] csr_addr_mcycle    = 12'hb00;
    localparam logic [11:0] csr_addr_minstret  = 12'hb02;
    localparam logic [11:0] csr_addr_mvendorid = 12'hf11;
    localparam logic [11:0] csr_addr_marchid   = 12'hf12;
    localparam logic [11:0] csr_addr_mimpid    = 12'hf13;
    localparam logic [11:0] csr_addr_mhartid   = 12'hf14;

    // user aliases, read only
    localparam logic [11:0] csr_addr_cycle     = 12'hc00;
    localparam logic [11:0] csr_addr_time      = 12'hc01;  // same counter as cycle
    localparam logic [11:0] csr_addr_instret   = 12'hc02;

    localparam logic [xlen-1:0] mvendorid_value = 64'h0000_0000_0000_0000;  // non-commercial
    localparam logic [xlen-1:0] marchid_value   = 64'h0000_0000_0000_0023;
    localparam logic [xlen-1:0] mimpid_value    = 64'h0000_0000_0001_0400;

    localparam logic [6:0] opcode_system = 7'b1110011;

    localparam logic [5:0] cause_illegal_instr = 6'd2;

    typedef enum logic [1:0] {
        csr_op_write = 2'd0,
        csr_op_set   = 2'd1,
        csr_op_clear = 2'd2
    } csr_op_e;

    // decode -> execute
    typedef struct packed {
        logic            valid;
        logic            illegal;
        logic [31:0]     instr;
        logic [11:0]     addr;
        csr_op_e         op;
        logic [4:0]      rd;
        logic [xlen-1:0] src;      // zero-extended uimm or rs1 data
        logic            do_read;
        logic            do_write;
    } csr_req_t;

    // execute -> result
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            do_read;
        logic            exception;
        logic [xlen-1:0] old_value;
        logic [31:0]     instr;
    } csr_exec_t;

    // writeback record to the core
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            we;
        logic [xlen-1:0] data;
        logic            exception;
        logic [5:0]      cause;
        logic [xlen-1:0] tval;
    } csr_wb_t;

endpackage

// File: source/csr_counters.sv
module csr_counters (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_retired,
    input  logic                     cycle_we,
    input  logic                     instret_we,
    input  logic [csr_pkg::xlen-1:0] wdata,
    output logic [csr_pkg::xlen-1:0] cycle_count,
    output logic [csr_pkg::xlen-1:0] instret_count
);

    logic [$bits(cycle_count)-1:0]   cycle_next;
    logic [$bits(instret_count)-1:0] instret_next;

    // explicit write wins over the increment
    always_comb begin
        if (cycle_we) begin
            cycle_next = wdata;
        end else begin
            cycle_next = cycle_count + 1'b1;  // free running
        end
    end

    always_comb begin
        if (instret_we) begin
            instret_next = wdata;
        end else if (inst_retired) begin
            instret_next = instret_count + 1'b1;
        end else begin
            instret_next = instret_count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count   <= '0;
            instret_count <= '0;
        end else begin
            cycle_count   <= cycle_next;
            instret_count <= instret_next;
        end
    end

endmodule

// File: source/csr_decode.sv
module csr_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  logic [31:0]              instr,
    input  logic [csr_pkg::xlen-1:0] rs1_data,
    output csr_pkg::csr_req_t        req
);
    import csr_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs1_uimm;
    logic       write_form;
    logic       illegal;
    csr_req_t   req_d;

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_uimm = instr[19:15];

    // funct3 000 and 100 are not Zicsr (ecall, ebreak, xret land here)
    assign illegal    = (opcode != opcode_system) || (funct3[1:0] == 2'b00);
    assign write_form = (funct3[1:0] == 2'b01);

    always_comb begin
        req_d       = '0;
        req_d.valid = instr_valid;
        req_d.illegal = illegal;
        req_d.instr = instr;
        req_d.addr  = instr[31:20];
        req_d.rd    = rd;

        case (funct3[1:0])
            2'b10:   req_d.op = csr_op_set;
            2'b11:   req_d.op = csr_op_clear;
            default: req_d.op = csr_op_write;
        endcase

        if (funct3[2]) begin
            req_d.src = {{(xlen-5){1'b0}}, rs1_uimm};  // immediate forms
        end else begin
            req_d.src = rs1_data;
        end

        // set/clear with a zero source field performs no write at all
        req_d.do_write = !illegal && (write_form || (rs1_uimm != 5'd0));
        req_d.do_read  = !(write_form && (rd == 5'd0));
    end

    always_ff @(posedge clk) begin
        req <= req_d;
        if (rst) begin
            req.valid <= 1'b0;
        end
    end

    // a rejected instruction must never reach execute as a write
    a_illegal_no_write: assert property (
        @(posedge clk) disable iff (rst)
        req.valid && req.illegal |-> !req.do_write
    ) else $error("illegal request carries a write");

endmodule

// File: source/csr_file.sv
module csr_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_retired,
    input  csr_pkg::csr_req_t  req,
    output csr_pkg::csr_exec_t exec
);
    import csr_pkg::*;

    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] cycle_count;
    logic [xlen-1:0] instret_count;
    logic [xlen-1:0] old_value;
    logic [xlen-1:0] new_value;
    logic            addr_ok;
    logic            read_only;
    logic            exception;
    logic            commit;
    logic            mscratch_we;
    logic            cycle_we;
    logic            instret_we;

    // aliases map onto the machine counters
    always_comb begin
        addr_ok = 1'b1;
        case (req.addr)
            csr_addr_mscratch:  old_value = mscratch;
            csr_addr_mcycle:    old_value = cycle_count;
            csr_addr_cycle:     old_value = cycle_count;
            csr_addr_time:      old_value = cycle_count;  // no separate timer
            csr_addr_minstret:  old_value = instret_count;
            csr_addr_instret:   old_value = instret_count;
            csr_addr_mvendorid: old_value = mvendorid_value;
            csr_addr_marchid:   old_value = marchid_value;
            csr_addr_mimpid:    old_value = mimpid_value;
            csr_addr_mhartid:   old_value = '0;  // single hart
            default: begin
                addr_ok   = 1'b0;
                old_value = '0;
            end
        endcase
    end

    // top two address bits set means read-only space
    assign read_only = (req.addr[11:10] == 2'b11);
    assign exception = req.illegal || !addr_ok || (req.do_write && read_only);

    always_comb begin
        case (req.op)
            csr_op_set:   new_value = old_value | req.src;
            csr_op_clear: new_value = old_value & ~req.src;
            default:      new_value = req.src;
        endcase
    end

    assign commit      = req.valid && !exception && req.do_write;
    assign mscratch_we = commit && (req.addr == csr_addr_mscratch);
    assign cycle_we    = commit && (req.addr == csr_addr_mcycle);
    assign instret_we  = commit && (req.addr == csr_addr_minstret);

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
        end else if (mscratch_we) begin
            mscratch <= new_value;
        end
    end

    csr_counters counters0 (
        .clk          (clk),
        .rst          (rst),
        .inst_retired (inst_retired),
        .cycle_we     (cycle_we),
        .instret_we   (instret_we),
        .wdata        (new_value),
        .cycle_count  (cycle_count),
        .instret_count(instret_count)
    );

    always_comb begin
        exec           = '0;
        exec.valid     = req.valid;
        exec.rd        = req.rd;
        exec.do_read   = req.do_read;
        exec.exception = exception;
        exec.old_value = old_value;
        exec.instr     = req.instr;
    end

    // an excepted instruction leaves mscratch alone and the counters on their normal course
    a_no_write_on_exception: assert property (
        @(posedge clk) disable iff (rst)
        exec.valid && exec.exception |=>
            (mscratch == $past(mscratch)) &&
            (cycle_count == $past(cycle_count) + 1'b1) &&
            (instret_count ==
                $past(instret_count) + {{(xlen-1){1'b0}}, $past(inst_retired)})
    ) else $error("CSR state changed by an excepted instruction");

endmodule

// File: source/csr_result.sv
module csr_result (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_exec_t exec,
    output csr_pkg::csr_wb_t   wb
);
    import csr_pkg::*;

    logic    fault;
    csr_wb_t wb_d;

    assign fault = exec.valid && exec.exception;

    always_comb begin
        wb_d       = '0;
        wb_d.valid = exec.valid;
        wb_d.rd    = exec.rd;
        // do_read is low only for rd == 0
        wb_d.we    = exec.valid && !exec.exception && exec.do_read && (exec.rd != 5'd0);
        wb_d.data  = exec.old_value;
        wb_d.exception = fault;
        if (fault) begin
            wb_d.cause = cause_illegal_instr;
            wb_d.tval  = {{(xlen-32){1'b0}}, exec.instr};
        end
    end

    always_ff @(posedge clk) begin
        wb <= wb_d;
        if (rst) begin
            wb.valid <= 1'b0;
        end
    end

    // a trapped instruction never writes rd
    a_exception_blocks_we: assert property (
        @(posedge clk) disable iff (rst)
        wb.valid |-> !(wb.we && wb.exception)
    ) else $error("writeback with both we and exception");

endmodule

// File: source/csr_unit.sv
module csr_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  logic [31:0]              instr,
    input  logic [csr_pkg::xlen-1:0] rs1_data,
    input  logic                     inst_retired,
    output csr_pkg::csr_wb_t         wb
);
    import csr_pkg::*;

    csr_req_t  req;   // request register output
    csr_exec_t exec;  // combinational execute result

    csr_decode decode0 (
        .clk        (clk),
        .rst        (rst),
        .instr_valid(instr_valid),
        .instr      (instr),
        .rs1_data   (rs1_data),
        .req        (req)
    );

    // read and write in one cycle, so no forwarding between back-to-back ops
    csr_file file0 (
        .clk         (clk),
        .rst         (rst),
        .inst_retired(inst_retired),
        .req         (req),
        .exec        (exec)
    );

    csr_result result0 (
        .clk (clk),
        .rst (rst),
        .exec(exec),
        .wb  (wb)
    );

endmodule

// File: tests/csr_unit_tb.sv
module csr_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    logic            clk;
    logic            rst;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [xlen-1:0] rs1_data;
    logic            inst_retired;
    csr_wb_t         wb;

    logic [31:0]     rng;
    logic            retire_on;       // random retire pulses enabled
    logic [xlen-1:0] model_mscratch;
    logic [xlen-1:0] cycle_adj;       // mcycle minus edges, moved by writes
    logic [xlen-1:0] edges;           // edges since reset
    logic [xlen-1:0] pulses;          // retire pulses sampled since reset
    int              issued;
    int              wb_seen;
    csr_wb_t         exp_now;
    csr_wb_t         exp_d1;
    csr_wb_t         exp_d2;
    string           name_now;
    string           name_d1;
    string           name_d2;

    csr_unit dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .inst_retired(inst_retired),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // two-deep queue of expected records, lines up with the DUT pipeline
    always @(posedge clk) begin
        if (rst) begin
            edges   <= '0;
            pulses  <= '0;
            wb_seen <= 0;
        end else begin
            edges  <= edges + 64'd1;
            pulses <= pulses + 64'(inst_retired);
            if (wb.valid) begin
                wb_seen <= wb_seen + 1;
            end
        end
        exp_d1  <= exp_now;
        exp_d2  <= exp_d1;
        name_d1 <= name_now;
        name_d2 <= name_d1;
    end

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        stop_failed();
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("Mismatch in %s: %s expected %h, actual %h", test, field, expected, actual);
        stop_failed();
    endtask

    a_wb_latency: assert property (@(negedge clk) disable iff (rst)
        instr_valid |-> ##2 wb.valid)
        else report_failure("no writeback two cycles after an accepted instruction");

    a_wb_stray: assert property (@(negedge clk) disable iff (rst)
        wb.valid |-> $past(instr_valid, 2))
        else report_failure("writeback without an instruction two cycles earlier");

    a_wb_ctrl: assert property (@(negedge clk) disable iff (rst)
        wb.valid |-> ({wb.exception, wb.we, wb.rd} == {exp_d2.exception, exp_d2.we, exp_d2.rd}))
        else report_mismatch(name_d2, "exception/we/rd",
                             64'({exp_d2.exception, exp_d2.we, exp_d2.rd}),
                             64'({wb.exception, wb.we, wb.rd}));

    a_wb_data: assert property (@(negedge clk) disable iff (rst)
        wb.valid && !exp_d2.exception |-> (wb.data == exp_d2.data))
        else report_mismatch(name_d2, "data", exp_d2.data, wb.data);

    a_wb_cause: assert property (@(negedge clk) disable iff (rst)
        wb.valid |-> (wb.cause == exp_d2.cause))
        else report_mismatch(name_d2, "cause", 64'(exp_d2.cause), 64'(wb.cause));

    a_wb_tval: assert property (@(negedge clk) disable iff (rst)
        wb.valid |-> (wb.tval == exp_d2.tval))
        else report_mismatch(name_d2, "tval", exp_d2.tval, wb.tval);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand32();
        lo = rand32();
        return {hi, lo};
    endfunction

    function automatic logic [31:0] encode_csr(input logic [11:0] addr, input logic [4:0] field,
                                               input logic [2:0] funct3, input logic [4:0] rd);
        return {addr, field, funct3, rd, opcode_system};
    endfunction

    function automatic logic addr_known(input logic [11:0] addr);
        case (addr)
            csr_addr_mscratch, csr_addr_mcycle, csr_addr_minstret,
            csr_addr_mvendorid, csr_addr_marchid, csr_addr_mimpid, csr_addr_mhartid,
            csr_addr_cycle, csr_addr_time, csr_addr_instret: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // value seen in the execute cycle, one edge after issue
    function automatic logic [xlen-1:0] model_read(input logic [11:0] addr,
                                                   input logic retire_now);
        case (addr)
            csr_addr_mscratch: return model_mscratch;
            csr_addr_mcycle, csr_addr_cycle, csr_addr_time: return edges + 64'd1 + cycle_adj;
            csr_addr_minstret, csr_addr_instret: return pulses + 64'(retire_now);
            csr_addr_mvendorid: return mvendorid_value;
            csr_addr_marchid: return marchid_value;
            csr_addr_mimpid: return mimpid_value;
            default: return '0;  // mhartid and unknown
        endcase
    endfunction

    task automatic step(input logic valid, input logic [31:0] word, input logic [xlen-1:0] rs1,
                        input string name);
        logic [31:0]     r;
        logic [2:0]      funct3;
        logic [11:0]     addr;
        logic [4:0]      field;
        logic            bad;
        logic            writes;
        logic [xlen-1:0] old;
        logic [xlen-1:0] src;
        logic [xlen-1:0] result;
        @(posedge clk);
        #1;
        r            = rand32();
        inst_retired = retire_on & r[0];
        instr_valid  = valid;
        instr        = word;
        rs1_data     = rs1;
        exp_now      = '0;
        name_now     = name;
        funct3       = word[14:12];
        addr         = word[31:20];
        field        = word[19:15];
        if (valid) begin
            bad    = (word[6:0] != opcode_system) || (funct3[1:0] == 2'b00) || !addr_known(addr);
            writes = (funct3[1:0] == 2'b01) || (field != 5'd0);
            bad    = bad || (writes && (addr[11:10] == 2'b11));  // read-only space
            old    = model_read(addr, inst_retired);
            src    = funct3[2] ? 64'(field) : rs1;
            case (funct3[1:0])
                2'b01:   result = src;
                2'b10:   result = old | src;
                default: result = old & ~src;
            endcase
            if (!bad && writes) begin
                if (addr == csr_addr_mscratch) begin
                    model_mscratch = result;
                end
                if (addr == csr_addr_mcycle) begin
                    cycle_adj = result - (edges + 64'd2);  // lands two edges from now
                end
            end
            exp_now.valid     = 1'b1;
            exp_now.rd        = word[11:7];
            exp_now.we        = !bad && (word[11:7] != 5'd0);
            exp_now.data      = old;
            exp_now.exception = bad;
            if (bad) begin
                exp_now.cause = 6'd2;
                exp_now.tval  = 64'(word);
            end
            issued++;
        end
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            step(1'b0, '0, '0, "idle");
        end
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [4:0] rd, input string name);
        step(1'b1, encode_csr(addr, 5'd0, 3'b010, rd), '0, name);  // csrrs rd, addr, x0
    endtask

    task automatic random_mscratch_op(input string name);
        logic [31:0] r;
        logic [1:0]  kind;
        r    = rand32();
        kind = (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
        step(1'b1, encode_csr(csr_addr_mscratch, r[12:8], {r[2], kind}, r[7:3]), rand64(), name);
    endtask

    task automatic probe_id(input logic [11:0] addr);
        read_csr(addr, 5'd9, "id_read");
        step(1'b1, encode_csr(addr, 5'd3, 3'b001, 5'd4), rand64(), "id_write");
        step(1'b1, encode_csr(addr, 5'd0, 3'b101, 5'd4), '0, "id_write_imm");
        step(1'b1, encode_csr(addr, 5'd1, 3'b110, 5'd4), '0, "id_set_imm");
        step(1'b1, encode_csr(addr, 5'd0, 3'b011, 5'd4), rand64(), "id_clear_zero");
    endtask

    initial begin
        int              k;
        int              n;
        logic [31:0]     r;
        rst            = 1'b1;
        instr_valid    = 1'b0;
        instr          = '0;
        rs1_data       = '0;
        inst_retired   = 1'b0;
        rng            = 32'he7621f79;
        retire_on      = 1'b0;
        model_mscratch = '0;
        cycle_adj      = '0;
        issued         = 0;
        exp_now        = '0;
        name_now       = "reset";
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;

        // mscratch read-modify-write, mostly back to back
        for (int i = 0; i < 48; i++) begin
            random_mscratch_op("mscratch_rmw");
            r = rand32();
            if (r[1:0] == 2'b00) begin
                read_csr(csr_addr_mscratch, 5'd7, "mscratch_readback");
            end else if (r[1:0] == 2'b01) begin
                idle(1);
            end
        end
        read_csr(csr_addr_mscratch, 5'd7, "mscratch_readback");

        probe_id(csr_addr_mvendorid);
        probe_id(csr_addr_marchid);
        probe_id(csr_addr_mimpid);
        probe_id(csr_addr_mhartid);

        read_csr(csr_addr_mscratch, 5'd2, "mscratch_before");
        step(1'b1, encode_csr(12'h7c0, 5'd5, 3'b001, 5'd2), rand64(), "unknown_addr");
        step(1'b1, {csr_addr_mscratch, 5'd5, 3'b001, 5'd2, 7'b0110011}, rand64(), "bad_opcode");
        step(1'b1, encode_csr(csr_addr_mscratch, 5'd5, 3'b000, 5'd2), rand64(), "funct3_000");
        step(1'b1, encode_csr(csr_addr_mscratch, 5'd5, 3'b100, 5'd2), rand64(), "funct3_100");
        read_csr(csr_addr_mscratch, 5'd2, "mscratch_kept");

        step(1'b1, encode_csr(csr_addr_mscratch, 5'd8, 3'b001, 5'd0), rand64(), "rd_zero");
        read_csr(csr_addr_mscratch, 5'd0, "rd_zero_read");
        read_csr(csr_addr_mscratch, 5'd3, "rd_zero_readback");

        // counters, k cycles between cycle reads
        read_csr(csr_addr_cycle, 5'd10, "cycle_first");
        k = 1 + int'(rand32() % 8);
        idle(k);
        read_csr(csr_addr_cycle, 5'd11, "cycle_second");
        read_csr(csr_addr_time, 5'd12, "time_vs_cycle");
        step(1'b1, encode_csr(csr_addr_mcycle, 5'd6, 3'b001, 5'd13), rand64(), "mcycle_write");
        idle(1);
        read_csr(csr_addr_mcycle, 5'd14, "mcycle_after_write");
        step(1'b1, encode_csr(csr_addr_mcycle, 5'd6, 3'b001, 5'd13), rand64(), "mcycle_write");
        read_csr(csr_addr_cycle, 5'd14, "cycle_back_to_back");

        retire_on = 1'b1;
        read_csr(csr_addr_minstret, 5'd15, "minstret_first");
        n = 10 + int'(rand32() % 20);
        for (int i = 0; i < n; i++) begin
            r = rand32();
            if (r[3]) begin
                random_mscratch_op("retire_run");
            end else begin
                idle(1);
            end
        end
        read_csr(csr_addr_instret, 5'd16, "instret_second");
        read_csr(csr_addr_minstret, 5'd17, "minstret_third");
        retire_on = 1'b0;
        idle(2);
        read_csr(csr_addr_instret, 5'd18, "instret_settled");
        idle(1);

        for (int t = 0; t < 20 && wb_seen != issued; t++) begin
            @(posedge clk);
            #1;
        end
        if (wb_seen != issued) begin
            report_failure("timeout waiting for the last writebacks");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: filelist.f
source/csr_pkg.sv
source/csr_counters.sv
source/csr_decode.sv
source/csr_file.sv
source/csr_result.sv
source/csr_unit.sv
tests/csr_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "test: pass"; \
	else \
		echo "test: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
